// ==== tile_video_pkg.sv ====
//////////////////////////////////////////////////
// Tile layer video package
// Raster geometry, pixel and tile widths and the
// beam position and pixel output structs
//////////////////////////////////////////////////

`default_nettype none

package tile_video_pkg;

    localparam int H_TOTAL     = 384;
    localparam int H_VISIBLE   = 256;
    localparam int V_TOTAL     = 264;
    localparam int V_FIRST     = 16;
    localparam int V_LAST      = 239;
    localparam int FIXED_COLS  = 4;     // Left tile columns that ignore scroll
    localparam int PIPE_PIXELS = 12;    // Beam position to pixel_out latency

    typedef logic [8:0]  hpos_t;        // 0 to 383
    typedef logic [7:0]  vpos_t;        // Line count modulo 256
    typedef logic [3:0]  color_t;
    typedef logic [7:0]  pal_addr_t;    // {attr palette, pixel}
    typedef logic [12:0] rom_addr_t;    // {code msb, code, row}
    typedef logic [31:0] rom_word_t;    // One tile row, 8 pixels of 4 bits

    typedef struct packed {
        hpos_t h;
        vpos_t v;
        logic  hblank_n;
        logic  vblank_n;
    } screen_pos_t;

    typedef struct packed {
        color_t color;
        hpos_t  x;
        vpos_t  y;
        logic   de;
    } pixel_out_t;

endpackage

`default_nettype wire

// ==== tile_bus_pkg.sv ====
//////////////////////////////////////////////////
// CPU bus package
// Byte-wide Wishbone structs and address map
//////////////////////////////////////////////////

`default_nettype none

package tile_bus_pkg;

    typedef logic [11:0] wb_addr_t;
    typedef logic [7:0]  wb_data_t;

    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;
        wb_data_t dat;
    } wb_req_t;

    typedef struct packed {
        logic     ack;
        wb_data_t dat;
    } wb_rsp_t;

    // 1 KB attribute and code VRAMs, two registers, 256 palette entries
    localparam wb_addr_t ATTR_BASE   = 12'h000;
    localparam wb_addr_t CODE_BASE   = 12'h400;
    localparam wb_addr_t SCROLL_ADDR = 12'h800;
    localparam wb_addr_t CTRL_ADDR   = 12'h801;
    localparam wb_addr_t PAL_BASE    = 12'hC00;

endpackage

`default_nettype wire

// ==== dual_port_ram.sv ====
//////////////////////////////////////////////////
// 1024x8 dual port RAM
// CPU read/write port and video read port,
// one clk of read latency on both
//////////////////////////////////////////////////

`default_nettype none

module dual_port_ram (
    input  logic                   clk,
    input  logic [9:0]             cpu_addr,
    input  tile_bus_pkg::wb_data_t cpu_din,
    input  logic                   cpu_we,
    output tile_bus_pkg::wb_data_t cpu_dout,
    input  logic [9:0]             vid_addr,
    output logic [7:0]             vid_dout
);
    import tile_bus_pkg::*;

    wb_data_t mem [1024];

    // CPU side, old data on a write
    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_din;
        end
        cpu_dout <= mem[cpu_addr];
    end

    // Video side never writes
    always_ff @(posedge clk) begin
        vid_dout <= mem[vid_addr];
    end

endmodule

`default_nettype wire

// ==== palette_prom.sv ====
//////////////////////////////////////////////////
// Palette colour table
// 256 entries of 4 bits, loaded by the CPU and
// read by video once per pixel
//////////////////////////////////////////////////

`default_nettype none

module palette_prom (
    input  logic                      clk,
    input  tile_video_pkg::pal_addr_t cpu_addr,
    input  tile_video_pkg::color_t    cpu_din,
    input  logic                      cpu_we,
    output tile_video_pkg::color_t    cpu_dout,
    input  logic                      pxl_cen,
    input  tile_video_pkg::pal_addr_t vid_addr,
    output tile_video_pkg::color_t    color
);
    import tile_video_pkg::*;

    color_t mem [256];

    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_din;
        end
        cpu_dout <= mem[cpu_addr];
    end

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            color <= mem[vid_addr];     // Held between pixel enables
        end
    end

endmodule

`default_nettype wire

// ==== raster_counter.sv ====
//////////////////////////////////////////////////
// Raster counter
// Pixel enable at half clk rate, beam position
// and blanking flags
//////////////////////////////////////////////////

`default_nettype none

module raster_counter (
    input  logic                        clk,
    input  logic                        rst,
    output logic                        pxl_cen,
    output tile_video_pkg::screen_pos_t pos
);
    import tile_video_pkg::*;

    logic       cen;
    hpos_t      h;
    logic [8:0] line_cnt;   // 0 to 263

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen      <= 1'b0;
            h        <= '0;
            line_cnt <= '0;
        end else begin
            cen <= ~cen;
            if (cen) begin
                if (h == hpos_t'(H_TOTAL - 1)) begin
                    h <= '0;
                    if (line_cnt == 9'(V_TOTAL - 1)) begin
                        line_cnt <= '0;
                    end else begin
                        line_cnt <= line_cnt + 9'd1;
                    end
                end else begin
                    h <= h + hpos_t'(1);
                end
            end
        end
    end

    assign pxl_cen = cen;

    always_comb begin
        pos.h        = h;
        pos.v        = line_cnt[7:0];   // Lines 256 to 263 fold onto 0 to 7
        pos.hblank_n = (h < hpos_t'(H_VISIBLE));
        pos.vblank_n = (line_cnt >= 9'(V_FIRST)) && (line_cnt <= 9'(V_LAST));
    end

endmodule

`default_nettype wire

// ==== bus_decoder.sv ====
//////////////////////////////////////////////////
// Wishbone slave of the tile layer
// Address decode, scroll and control registers,
// read data select and one clk acknowledge
//////////////////////////////////////////////////

`default_nettype none

module bus_decoder (
    input  logic                   clk,
    input  logic                   rst,
    input  tile_bus_pkg::wb_req_t  req,
    output tile_bus_pkg::wb_rsp_t  rsp,
    output logic [9:0]             ram_addr,
    output tile_bus_pkg::wb_data_t ram_din,
    output logic                   attr_we,
    output logic                   code_we,
    output logic                   pal_we,
    input  tile_bus_pkg::wb_data_t attr_dout,
    input  tile_bus_pkg::wb_data_t code_dout,
    input  tile_video_pkg::color_t pal_dout,
    output tile_bus_pkg::wb_data_t scroll,
    output logic                   flip
);
    import tile_bus_pkg::*;

    logic     ack;
    logic     start;
    logic     in_attr, in_code, in_pal, is_scroll, is_ctrl;
    logic     sel_attr, sel_code, sel_pal;
    wb_data_t reg_q;    // Register or unmapped read value

    assign start     = req.cyc & req.stb & ~ack;
    assign in_attr   = (req.adr[11:10] == ATTR_BASE[11:10]);
    assign in_code   = (req.adr[11:10] == CODE_BASE[11:10]);
    assign in_pal    = (req.adr[11:8] == PAL_BASE[11:8]);
    assign is_scroll = (req.adr == SCROLL_ADDR);
    assign is_ctrl   = (req.adr == CTRL_ADDR);

    // Writes land on the edge that raises ack
    assign ram_addr = req.adr[9:0];
    assign ram_din  = req.dat;
    assign attr_we  = start & req.we & in_attr;
    assign code_we  = start & req.we & in_code;
    assign pal_we   = start & req.we & in_pal;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack      <= 1'b0;
            sel_attr <= 1'b0;
            sel_code <= 1'b0;
            sel_pal  <= 1'b0;
            reg_q    <= '0;
            scroll   <= '0;
            flip     <= 1'b0;
        end else begin
            ack <= req.cyc & req.stb;   // Stays up until stb drops
            if (start) begin
                sel_attr <= in_attr;
                sel_code <= in_code;
                sel_pal  <= in_pal;
                reg_q    <= is_scroll ? scroll : (is_ctrl ? {7'd0, flip} : '0);
                if (req.we && is_scroll) begin
                    scroll <= req.dat;
                end
                if (req.we && is_ctrl) begin
                    flip <= req.dat[0];
                end
            end
        end
    end

    // RAM read data arrives together with ack
    assign rsp.ack = ack;
    assign rsp.dat = sel_attr ? attr_dout :
                     sel_code ? code_dout :
                     sel_pal  ? {4'd0, pal_dout} : reg_q;

endmodule

`default_nettype wire

// ==== scroll_tilemap.sv ====
//////////////////////////////////////////////////
// Scrolling tilemap engine
// 32x32 map of 8x8 tiles with column scroll,
// tile and screen flip, ROM fetch and palette
//////////////////////////////////////////////////

`default_nettype none

module scroll_tilemap (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        pxl_cen,
    input  tile_video_pkg::screen_pos_t pos,
    input  tile_bus_pkg::wb_data_t      scroll,
    input  logic                        flip,
    input  logic [9:0]                  ram_addr,
    input  tile_bus_pkg::wb_data_t      ram_din,
    input  logic                        attr_we,
    input  logic                        code_we,
    input  logic                        pal_we,
    output tile_bus_pkg::wb_data_t      attr_dout,
    output tile_bus_pkg::wb_data_t      code_dout,
    output tile_video_pkg::color_t      pal_dout,
    output tile_video_pkg::rom_addr_t   rom_addr,
    input  tile_video_pkg::rom_word_t   rom_data,
    output tile_video_pkg::pixel_out_t  pixel
);
    import tile_video_pkg::*;

    hpos_t       fetch_h;
    logic [7:0]  col;
    logic        fixed;
    vpos_t       line;
    logic [9:0]  map_addr;
    logic [7:0]  attr_q, code_q;
    logic [2:0]  row;
    rom_word_t   rom_pix;
    rom_word_t   shift_q;
    color_t      nxt_pal, cur_pal;
    logic        nxt_dir, cur_dir;
    color_t      pix;
    pal_addr_t   pal_rd;
    color_t      pal_color;
    screen_pos_t pos_dly [PIPE_PIXELS-1];

    // Fetch trails the beam so that the 7 pixels of fetch, shift,
    // palette and output latency add up to PIPE_PIXELS
    always_comb begin
        if (pos.h >= hpos_t'(PIPE_PIXELS - 7)) begin
            fetch_h = pos.h - hpos_t'(PIPE_PIXELS - 7);
        end else begin
            fetch_h = pos.h + hpos_t'(H_TOTAL - PIPE_PIXELS + 7);
        end
    end

    assign col      = fetch_h[7:0] ^ {8{flip}};        // Tilemap column
    assign fixed    = (col < 8'(FIXED_COLS * 8));
    assign line     = (pos.v ^ {8{flip}}) + (fixed ? 8'd0 : scroll);
    assign map_addr = {line[7:3], col[7:3]};
    assign row      = line[2:0] ^ {3{attr_q[5]}};      // vflip

    // Pixel k takes bit 7-k of each byte
    always_comb begin
        for (int k = 0; k < 8; k++) begin
            for (int p = 0; p < 4; p++) begin
                rom_pix[4*k+p] = rom_data[8*p+7-k];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            if (fetch_h[2:0] == 3'd0) begin
                rom_addr <= {attr_q[7:6], code_q, row};
                nxt_pal  <= attr_q[3:0];
                nxt_dir  <= attr_q[4] ^ flip;
            end
            if (fetch_h[2:0] == 3'd4) begin    // ROM word is settled by now
                shift_q <= rom_pix;
                cur_pal <= nxt_pal;
                cur_dir <= nxt_dir;
            end else if (cur_dir) begin
                shift_q <= shift_q << 4;
            end else begin
                shift_q <= shift_q >> 4;
            end
        end
    end

    assign pix    = cur_dir ? shift_q[31:28] : shift_q[3:0];
    assign pal_rd = {cur_pal, pix};

    // Beam position follows the colour through the pipe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < PIPE_PIXELS - 1; i++) begin
                pos_dly[i] <= '0;
            end
            pixel <= '0;
        end else if (pxl_cen) begin
            pos_dly[0] <= pos;
            for (int i = 1; i < PIPE_PIXELS - 1; i++) begin
                pos_dly[i] <= pos_dly[i-1];
            end
            pixel.color <= pal_color;
            pixel.x     <= pos_dly[PIPE_PIXELS-2].h;
            pixel.y     <= pos_dly[PIPE_PIXELS-2].v;
            pixel.de    <= pos_dly[PIPE_PIXELS-2].hblank_n & pos_dly[PIPE_PIXELS-2].vblank_n;
        end
    end

    dual_port_ram u_attr_ram (
        .clk      (clk),
        .cpu_addr (ram_addr),
        .cpu_din  (ram_din),
        .cpu_we   (attr_we),
        .cpu_dout (attr_dout),
        .vid_addr (map_addr),
        .vid_dout (attr_q)
    );

    dual_port_ram u_code_ram (
        .clk      (clk),
        .cpu_addr (ram_addr),
        .cpu_din  (ram_din),
        .cpu_we   (code_we),
        .cpu_dout (code_dout),
        .vid_addr (map_addr),
        .vid_dout (code_q)
    );

    palette_prom u_palette (
        .clk      (clk),
        .cpu_addr (ram_addr[7:0]),
        .cpu_din  (ram_din[3:0]),
        .cpu_we   (pal_we),
        .cpu_dout (pal_dout),
        .pxl_cen  (pxl_cen),
        .vid_addr (pal_rd),
        .color    (pal_color)
    );

endmodule

`default_nettype wire

// ==== tilemap_top.sv ====
//////////////////////////////////////////////////
// Tile layer top level
// CPU bus slave, raster counter and tilemap
//////////////////////////////////////////////////

`default_nettype none

module tilemap_top (
    input  logic                       clk,
    input  logic                       rst,
    input  tile_bus_pkg::wb_req_t      wb_req,
    output tile_bus_pkg::wb_rsp_t      wb_rsp,
    output tile_video_pkg::rom_addr_t  rom_addr,
    input  tile_video_pkg::rom_word_t  rom_data,
    output tile_video_pkg::pixel_out_t pixel
);
    import tile_video_pkg::*;
    import tile_bus_pkg::*;

    logic        pxl_cen;
    screen_pos_t pos;
    logic [9:0]  ram_addr;
    wb_data_t    ram_din;
    logic        attr_we, code_we, pal_we;
    wb_data_t    attr_dout, code_dout;
    color_t      pal_dout;
    wb_data_t    scroll;
    logic        flip;

    raster_counter u_raster_counter (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .pos     (pos)
    );

    bus_decoder u_bus_decoder (
        .clk       (clk),
        .rst       (rst),
        .req       (wb_req),
        .rsp       (wb_rsp),
        .ram_addr  (ram_addr),
        .ram_din   (ram_din),
        .attr_we   (attr_we),
        .code_we   (code_we),
        .pal_we    (pal_we),
        .attr_dout (attr_dout),
        .code_dout (code_dout),
        .pal_dout  (pal_dout),
        .scroll    (scroll),
        .flip      (flip)
    );

    scroll_tilemap u_scroll_tilemap (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .pos       (pos),
        .scroll    (scroll),
        .flip      (flip),
        .ram_addr  (ram_addr),
        .ram_din   (ram_din),
        .attr_we   (attr_we),
        .code_we   (code_we),
        .pal_we    (pal_we),
        .attr_dout (attr_dout),
        .code_dout (code_dout),
        .pal_dout  (pal_dout),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .pixel     (pixel)
    );

endmodule

`default_nettype wire

// ==== tilemap_tb.sv ====
//////////////////////////////////////////////////
// Tile layer testbench
// Graphics ROM model, Wishbone master, reference
// model of VRAM and palette, pixel probes
//////////////////////////////////////////////////

`default_nettype none

module tilemap_tb;
    import tile_video_pkg::*;
    import tile_bus_pkg::*;

    localparam int FRAME_CLKS = 768 * 264;

    typedef struct packed {
        logic [7:0]  kind;      // W, R or P
        logic [31:0] a;
        logic [31:0] b;
    } line_t;

    logic       clk;
    logic       rst;
    wb_req_t    wb_req;
    wb_rsp_t    wb_rsp;
    rom_addr_t  rom_addr;
    rom_word_t  rom_data;
    pixel_out_t pixel;

    rom_word_t  rom_mem [8192];
    wb_data_t   attr_m [1024];
    wb_data_t   code_m [1024];
    color_t     pal_m [256];
    wb_data_t   scroll_m;
    logic       flip_m;
    line_t      lines [$];
    wb_addr_t   pending [$];
    int         cycles;
    int         cycle_limit;
    int         run_clks;

    tilemap_top u_tilemap_top (
        .clk      (clk),
        .rst      (rst),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .pixel    (pixel)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ROM answers one clk after the address
    always @(posedge clk) begin
        #1;
        rom_data = rom_mem[rom_addr];
    end

    // Clock edges since reset release, the beam starts from here
    always @(posedge clk) begin
        if (!rst) begin
            run_clks <= run_clks + 1;
        end
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            report_failure($sformatf("Timeout after %0d clock cycles", cycle_limit));
        end
    end

    task automatic check_data(input string name, input wb_data_t exp, input wb_data_t act);
        if (exp !== act) begin
            report_failure($sformatf("FAILED %s expected %02h actual %02h", name, exp, act));
        end
    endtask

    task automatic check_color(input string name, input color_t exp, input color_t act);
        if (exp !== act) begin
            report_failure($sformatf("FAILED %s expected %01h actual %01h", name, exp, act));
        end
    endtask

    task automatic check_pos(input string name, input hpos_t exp, input hpos_t act);
        if (exp !== act) begin
            report_failure($sformatf("FAILED %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    // de follows the visible window of the position it carries
    always @(negedge clk) begin
        if (rst) begin
            check_data("de in reset", 8'd0, {7'd0, pixel.de});
        end else begin
            check_data($sformatf("de at %0d,%0d", pixel.x, pixel.y),
                       {7'd0, (pixel.x < 9'd256) && (pixel.y >= 8'd16) && (pixel.y <= 8'd239)},
                       {7'd0, pixel.de});
        end
    end

    function automatic wb_data_t model_read(input wb_addr_t adr);
        wb_data_t d;
        d = 8'd0;   // Unmapped
        if (adr[11:10] == 2'b00) begin
            d = attr_m[adr[9:0]];
        end else if (adr[11:10] == 2'b01) begin
            d = code_m[adr[9:0]];
        end else if (adr[11:8] == 4'hC) begin
            d = {4'd0, pal_m[adr[7:0]]};
        end else if (adr == SCROLL_ADDR) begin
            d = scroll_m;
        end else if (adr == CTRL_ADDR) begin
            d = {7'd0, flip_m};
        end
        return d;
    endfunction

    task automatic model_write(input wb_addr_t adr, input wb_data_t dat);
        if (adr[11:10] == 2'b00) begin
            attr_m[adr[9:0]] = dat;
        end else if (adr[11:10] == 2'b01) begin
            code_m[adr[9:0]] = dat;
        end else if (adr[11:8] == 4'hC) begin
            pal_m[adr[7:0]] = dat[3:0];
        end else if (adr == SCROLL_ADDR) begin
            scroll_m = dat;
        end else if (adr == CTRL_ADDR) begin
            flip_m = dat[0];
        end
    endtask

    // Reference pixel from map, ROM and palette copies
    function automatic color_t expect_color(input hpos_t x, input vpos_t y);
        logic [7:0] col;
        logic [7:0] ln;
        logic [9:0] idx;
        wb_data_t   a;
        wb_data_t   c;
        logic [2:0] r;
        rom_word_t  w;
        int         k;
        color_t     pix;
        col = x[7:0] ^ {8{flip_m}};
        ln  = y ^ {8{flip_m}};
        if (col >= 8'(FIXED_COLS * 8)) begin
            ln = ln + scroll_m;
        end
        idx = {ln[7:3], col[7:3]};
        a   = attr_m[idx];
        c   = code_m[idx];
        r   = ln[2:0] ^ {3{a[5]}};
        w   = rom_mem[{a[7:6], c, r}];
        k   = int'(col[2:0] ^ {3{a[4]}});
        for (int p = 0; p < 4; p++) begin
            pix[p] = w[8*p + 7 - k];
        end
        return pal_m[{a[3:0], pix}];
    endfunction

    task automatic bus_cycle(input logic we, input wb_addr_t adr, input wb_data_t dat,
                             output wb_data_t rdat);
        @(posedge clk);
        #1;
        check_data("ack before stb", 8'd0, {7'd0, wb_rsp.ack});
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        @(posedge clk);
        #1;
        check_data("ack one clk after stb", 8'd1, {7'd0, wb_rsp.ack});
        rdat   = wb_rsp.dat;
        wb_req = '0;
    endtask

    task automatic bus_write(input wb_addr_t adr, input wb_data_t dat);
        wb_data_t unused;
        bus_cycle(1'b1, adr, dat, unused);
        model_write(adr, dat);
    endtask

    task automatic read_back(input wb_addr_t adr);
        wb_data_t r;
        bus_cycle(1'b0, adr, 8'd0, r);
        check_data($sformatf("readback %03h", adr), model_read(adr), r);
    endtask

    // Random order over the writes of one group
    task automatic read_back_pending();
        int       j;
        wb_addr_t t;
        for (int i = pending.size() - 1; i > 0; i--) begin
            j          = int'($urandom % (i + 1));
            t          = pending[i];
            pending[i] = pending[j];
            pending[j] = t;
        end
        foreach (pending[i]) begin
            read_back(pending[i]);
        end
        pending.delete();
    endtask

    task automatic clear_memories();
        for (int i = 0; i < 1024; i++) begin
            bus_write(ATTR_BASE | wb_addr_t'(i), 8'd0);
            bus_write(CODE_BASE | wb_addr_t'(i), 8'd0);
        end
        for (int i = 0; i < 256; i++) begin
            bus_write(PAL_BASE | wb_addr_t'(i), 8'd0);
        end
    endtask

    task automatic wait_frame_start();
        do begin
            @(negedge clk);
        end while (pixel.y !== 8'd250);     // Past the visible lines
    endtask

    // Beam b leaves the pipe PIPE_PIXELS pixel enables later,
    // stable after clock edge 2 * (b + PIPE_PIXELS)
    task automatic check_probe(input hpos_t x, input vpos_t y);
        string name;
        int    beam;
        beam = int'(y) * H_TOTAL + int'(x);
        do begin
            @(negedge clk);
        end while (run_clks < 2 * PIPE_PIXELS || run_clks % 2 != 0 ||
                   ((run_clks - 2 * PIPE_PIXELS) / 2) % (H_TOTAL * V_TOTAL) != beam);
        name = $sformatf("pixel %0d,%0d", x, y);
        check_pos({name, " x"}, x, pixel.x);
        check_pos({name, " y"}, hpos_t'(y), hpos_t'(pixel.y));
        check_color(name, expect_color(x, y), pixel.color);
    endtask

    task automatic load_input();
        int          fd;
        int          n;
        string       text;
        logic [7:0]  kind;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("tilemap_input.txt", "r");
        if (fd == 0) begin
            report_failure("Could not open tilemap_input.txt");
        end
        while (!$feof(fd)) begin
            text = "";
            void'($fgets(text, fd));
            n = $sscanf(text, "%c %h %h", kind, a, b);
            if (n >= 3 && kind == "R") begin
                rom_mem[a[12:0]] = b;
            end else if (n >= 3 && (kind == "W" || kind == "P")) begin
                lines.push_back('{kind, a, b});
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int n_bus;
        int n_probe;
        void'($urandom(32'h7c59_bad9));
        rst         = 1'b1;
        wb_req      = '0;
        rom_data    = '0;
        cycles      = 0;
        run_clks    = 0;
        cycle_limit = 32'h7fff_ffff;
        scroll_m    = 8'd0;
        flip_m      = 1'b0;
        foreach (rom_mem[i]) begin
            rom_mem[i] = '0;
        end
        load_input();

        n_bus   = 2304;     // Memory clear
        n_probe = 0;
        foreach (lines[i]) begin
            if (lines[i].kind == "W") begin
                n_bus = n_bus + 2;
            end else begin
                n_probe = n_probe + 1;
            end
        end
        cycle_limit = n_bus * 4 + (2 * n_probe + 3) * FRAME_CLKS;

        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        clear_memories();
        foreach (lines[i]) begin
            if (lines[i].kind == "W") begin
                bus_write(lines[i].a[11:0], lines[i].b[7:0]);
                pending.push_back(lines[i].a[11:0]);
            end else begin
                if (pending.size() > 0) begin
                    read_back_pending();
                    wait_frame_start();
                end
                check_probe(lines[i].a[8:0], lines[i].b[7:0]);
            end
        end
        read_back_pending();

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
tile_video_pkg.sv
tile_bus_pkg.sv
dual_port_ram.sv
palette_prom.sv
raster_counter.sv
bus_decoder.sv
scroll_tilemap.sv
tilemap_top.sv
tilemap_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the tile layer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tilemap_tb \
    -f verilog.f -o tilemap_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tilemap_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0

// ==== tilemap_input.txt ====
# Tile layer test input, all values hex
# W addr data = bus write, R addr word = graphics ROM word, P x y = pixel probe
R 081 c3a50f96
R 085 5a3cf00f
R 086 0ff0a55a
R 88b 96e1c33c
W 085 01
W 485 10
W 081 41
W 481 11
W c10 0b
W c11 03
W c12 0e
W c13 a5
W c14 09
W c15 01
W c16 0c
W c17 06
W c18 0f
W c19 02
W c1a 08
W c1b 0d
W c1c 04
W c1d 0a
W c1e 07
W c1f 00
P 2a 21
P 2d 26
P 0a 23
W 800 08
P 2a 19
P 0a 23
W 085 31
P 2b 1a
W 801 01
W 800 00
P f5 dc
P d5 de
